/* src.f */
+incdir+design
+incdir+test
design/rpt_pkg.sv
design/rpt_commit_unit.sv
design/rpt_entry.sv
design/rpt_prefetch_arbiter.sv
design/stride_prefetcher.sv
test/tb_stride_prefetcher.sv

/* test/tb_stride_vectors.svh */
// Stride prefetcher test vectors

// each row holds pc, va, init, status, prefetch_en, ready held-low cycles, ack mode,
// standby right after the commit, request count and the expected request addresses.

localparam int NUM_VECS = 26;

localparam ld_status_t ATTR_A       = '{1'b1, 4'h2, 1'b0, 1'b0};
localparam ld_status_t ATTR_A_FAULT = '{1'b1, 4'h2, 1'b0, 1'b1};
localparam ld_status_t ATTR_B       = '{1'b0, 4'h5, 1'b0, 1'b0};
localparam ld_status_t ATTR_B_MT6   = '{1'b0, 4'h6, 1'b0, 1'b0};
localparam logic [0:3][`RPT_VA_BITS-1:0] NO_REQ = '0;

localparam vec_t VECS [NUM_VECS] = '{
    // stream a, stride 0x100.
    '{12'h101, 32'h1000_0000, 1'b1, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h101, 32'h1000_0100, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h101, 32'h1000_0200, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd3,
      '{32'h1000_0300, 32'h1000_0400, 32'h1000_0500, 32'h0}},
    '{12'h101, 32'h1000_0300, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd1,
      '{32'h1000_0600, 32'h0, 32'h0, 32'h0}},
    '{12'h101, 32'h1000_0400, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_REPLAY, 1'b0, 3'd2,
      '{32'h1000_0700, 32'h1000_0700, 32'h0, 32'h0}},
    '{12'h101, 32'h1000_0500, 1'b0, ATTR_A, 1'b1, 4'd8, MODE_PLAIN, 1'b0, 3'd1,
      '{32'h1000_0800, 32'h0, 32'h0, 32'h0}},
    // stride break, retrain at 0x140.
    '{12'h101, 32'h1000_0900, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h101, 32'h1000_0a40, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h101, 32'h1000_0b80, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd3,
      '{32'h1000_0cc0, 32'h1000_0e00, 32'h1000_0f40, 32'h0}},
    // stream b, stride 0x40.
    '{12'h2a7, 32'h2000_0000, 1'b1, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h2a7, 32'h2000_0040, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h2a7, 32'h2000_0080, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd3,
      '{32'h2000_00c0, 32'h2000_0100, 32'h2000_0140, 32'h0}},
    '{12'h101, 32'h1000_0cc0, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd1,
      '{32'h1000_1080, 32'h0, 32'h0, 32'h0}},
    '{12'h2a7, 32'h2000_00c0, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd1,
      '{32'h2000_0180, 32'h0, 32'h0, 32'h0}},
    // kills by attribute change and by fault.
    '{12'h2a7, 32'h2000_0100, 1'b0, ATTR_B_MT6, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h101, 32'h1000_0e00, 1'b0, ATTR_A_FAULT, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    // stream b stays dead and does not retrain.
    '{12'h2a7, 32'h2000_0140, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h2a7, 32'h2000_0180, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    // kill by error response.
    '{12'h333, 32'h3000_0000, 1'b1, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h333, 32'h3000_0080, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h333, 32'h3000_0100, 1'b0, ATTR_A, 1'b1, 4'd0, MODE_ERROR, 1'b0, 3'd1,
      '{32'h3000_0180, 32'h0, 32'h0, 32'h0}},
    // kill by prefetch_en low.
    '{12'h444, 32'h4000_0000, 1'b1, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h444, 32'h4000_0100, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h444, 32'h4000_0200, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b0, 3'd3,
      '{32'h4000_0300, 32'h4000_0400, 32'h4000_0500, 32'h0}},
    '{12'h444, 32'h4000_0300, 1'b0, ATTR_B, 1'b0, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ},
    '{12'h444, 32'h4000_0400, 1'b0, ATTR_B, 1'b1, 4'd0, MODE_PLAIN, 1'b1, 3'd0, NO_REQ}
};

/* test/tb_stride_prefetcher.sv */
// Stride prefetcher testbench
`timescale 1ns/1ps
`default_nettype none
`include "rpt_settings.svh"

module tb_stride_prefetcher
    import rpt_pkg::*;
();

    localparam logic [31:0] LFSR_SEED   = 32'hbc9423f7;
    localparam int          ROW_TIMEOUT = 2000;
    localparam int          ACK_DELAY   = 2;
    localparam int          RESP_DELAY  = 3;
    localparam logic [1:0]  MODE_PLAIN  = 2'd0;
    localparam logic [1:0]  MODE_REPLAY = 2'd1; // first ack of the row asks for replay.
    localparam logic [1:0]  MODE_ERROR  = 2'd2; // first response of the row fails.
    localparam int          PH_IDLE     = 0;
    localparam int          PH_ACK      = 1;
    localparam int          PH_RESP     = 2;

    typedef struct packed {
        logic [`RPT_PC_BITS-1:0]        pc;
        logic [`RPT_VA_BITS-1:0]        va;
        logic                           init;
        ld_status_t                     status;
        logic                           en;
        logic [3:0]                     bp;
        logic [1:0]                     mode;
        logic                           standby;
        logic [2:0]                     n_exp;
        logic [0:3][`RPT_VA_BITS-1:0]   exp_va;
    } vec_t;

`include "tb_stride_vectors.svh"

    logic       core_clk;
    logic       core_reset_n;
    logic       prefetch_en;
    logic       cmt_valid;
    ld_commit_t cmt;
    logic       prf_valid;
    prf_req_t   prf_req;
    logic       prf_ready       = 1'b0;
    logic       prf_ack_valid   = 1'b0;
    logic       prf_ack_replay  = 1'b0;
    logic       prf_resp_valid  = 1'b0;
    logic       prf_resp_status = 1'b0;
    logic       standby_ready;

    // memory side model state.
    logic [31:0] lfsr = LFSR_SEED;
    logic [31:0] lfsr_n;
    int          mem_phase   = PH_IDLE;
    int          mem_wait    = 0;
    int          bp_row      = -1;
    int          bp_left     = 0;
    int          special_row = -1;
    int          row_id      = -1;
    int          row_bp      = 0;
    logic [1:0]  row_mode    = MODE_PLAIN;
    logic        replay_now;
    logic        error_now;
    logic        hold_valid  = 1'b0;
    prf_req_t    hold_req    = '0;
    prf_req_t    got_q [$];

    int          check_count = 0;
    int          error_count = 0;
    bit          timed_out   = 1'b0;

    stride_prefetcher dut_i (
        .core_clk        (core_clk),
        .core_reset_n    (core_reset_n),
        .prefetch_en     (prefetch_en),
        .cmt_valid       (cmt_valid),
        .cmt             (cmt),
        .prf_valid       (prf_valid),
        .prf_req         (prf_req),
        .prf_ready       (prf_ready),
        .prf_ack_valid   (prf_ack_valid),
        .prf_ack_replay  (prf_ack_replay),
        .prf_resp_valid  (prf_resp_valid),
        .prf_resp_status (prf_resp_status),
        .standby_ready   (standby_ready)
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic check_req(input prf_req_t exp, input prf_req_t got, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s expected %h/%h/%b/%h got %h/%h/%b/%h", $time, what,
                     exp.pc, exp.va, exp.vm, exp.mtype, got.pc, got.va, got.vm, got.mtype);
        end
    endtask

    task automatic check_standby(input bit exp, input bit got, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    // done once every entry is quiet and the memory side has drained.
    task automatic wait_row_done(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < ROW_TIMEOUT) begin
            @(posedge core_clk);
            ok = standby_ready && (mem_phase == PH_IDLE);
            cycles++;
        end
    endtask

    assign lfsr_n     = lfsr_next(lfsr);
    assign replay_now = (row_mode == MODE_REPLAY) && (special_row != row_id);
    assign error_now  = (row_mode == MODE_ERROR) && (special_row != row_id);

    always @(posedge core_clk) begin
        prf_ack_valid   <= 1'b0;
        prf_ack_replay  <= 1'b0;
        prf_resp_valid  <= 1'b0;
        prf_resp_status <= 1'b0;
        if (!core_reset_n) begin
            mem_phase <= PH_IDLE;
            prf_ready <= 1'b0;
        end else begin
            if (hold_valid && prf_valid) begin
                check_req(hold_req, prf_req, "held request");
            end
            hold_valid <= prf_valid & ~prf_ready;
            hold_req   <= prf_req;
            case (mem_phase)
                PH_IDLE: begin
                    if (prf_valid && prf_ready) begin
                        got_q.push_back(prf_req);
                        prf_ready <= 1'b0; // one request at a time.
                        mem_wait  <= ACK_DELAY;
                        mem_phase <= PH_ACK;
                    end else if (bp_row != row_id) begin
                        bp_row    <= row_id;
                        bp_left   <= row_bp;
                        prf_ready <= 1'b0;
                    end else if (bp_left != 0) begin
                        bp_left   <= bp_left - 1;
                        prf_ready <= 1'b0;
                    end else begin
                        lfsr      <= lfsr_n;
                        prf_ready <= lfsr_n[0];
                    end
                end
                PH_ACK: begin
                    if (mem_wait != 0) begin
                        mem_wait <= mem_wait - 1;
                    end else begin
                        prf_ack_valid  <= 1'b1;
                        prf_ack_replay <= replay_now;
                        mem_wait       <= RESP_DELAY;
                        mem_phase      <= replay_now ? PH_IDLE : PH_RESP;
                        if (replay_now) begin
                            special_row <= row_id;
                        end
                    end
                end
                default: begin
                    if (mem_wait != 0) begin
                        mem_wait <= mem_wait - 1;
                    end else begin
                        prf_resp_valid  <= 1'b1;
                        prf_resp_status <= error_now;
                        mem_phase       <= PH_IDLE;
                        if (error_now) begin
                            special_row <= row_id;
                        end
                    end
                end
            endcase
        end
    end

    initial begin : stimulus
        ld_commit_t c;
        prf_req_t   exp_req;
        bit         ok;
        int         row_err;
        int         rows_done;
        core_reset_n = 1'b0;
        prefetch_en  = 1'b0;
        cmt_valid    = 1'b0;
        cmt          = '0;
        rows_done    = 0;
        repeat (10) @(posedge core_clk);
        core_reset_n <= 1'b1;
        prefetch_en  <= 1'b1;
        @(posedge core_clk);
        check_standby(1'b1, standby_ready, "standby after reset");
        for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
            row_err  = error_count;
            c.pc     = VECS[i].pc;
            c.va     = VECS[i].va;
            c.init   = VECS[i].init;
            c.status = VECS[i].status;
            cmt         <= c;
            cmt_valid   <= 1'b1;
            prefetch_en <= VECS[i].en;
            row_id      <= i;
            row_bp      <= int'(VECS[i].bp);
            row_mode    <= VECS[i].mode;
            @(posedge core_clk);
            cmt_valid <= 1'b0;
            @(posedge core_clk);
            check_standby(VECS[i].standby, standby_ready, "standby after commit");
            wait_row_done(ok);
            if (!ok) begin
                error_count++;
                timed_out = 1'b1;
                $display("row %0d timed out waiting for the prefetcher to go idle", i);
            end else if (got_q.size() != int'(VECS[i].n_exp)) begin
                error_count++;
                $display("mismatch at %0t: row %0d sent %0d requests, expected %0d", $time, i,
                         got_q.size(), VECS[i].n_exp);
            end
            for (int k = 0; k < got_q.size() && k < int'(VECS[i].n_exp); k++) begin
                exp_req.pc    = VECS[i].pc;
                exp_req.va    = VECS[i].exp_va[k];
                exp_req.vm    = VECS[i].status.vm;
                exp_req.mtype = VECS[i].status.mtype;
                check_req(exp_req, got_q[k], "prefetch request");
            end
            $display("row %0d: %0d requests, %0d errors", i, got_q.size(), error_count - row_err);
            got_q.delete();
            rows_done++;
        end
        $display("rows %0d, checks %0d, errors %0d", rows_done, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/stride_prefetcher.sv */
// Stride prefetcher top level
`timescale 1ns/1ps
`default_nettype none
`include "rpt_settings.svh"

module stride_prefetcher
    import rpt_pkg::*;
(
    input  wire logic       core_clk,
    input  wire logic       core_reset_n,
    input  wire logic       prefetch_en,
    input  wire logic       cmt_valid,
    input  wire ld_commit_t cmt,
    output logic            prf_valid,
    output prf_req_t        prf_req,
    input  wire logic       prf_ready,
    input  wire logic       prf_ack_valid,
    input  wire logic       prf_ack_replay,
    input  wire logic       prf_resp_valid,
    input  wire logic       prf_resp_status,
    output logic            standby_ready
);

    localparam int N = `RPT_ENTRIES;

    entry_cmt_t   entry_cmt [N];
    prf_req_t     ent_req [N];
    logic [N-1:0] cmp_hit;
    logic [N-1:0] ent_valid;
    logic [N-1:0] ent_ready;
    logic [N-1:0] ent_ack_valid;
    logic [N-1:0] ent_ack_replay;
    logic [N-1:0] ent_resp_valid;
    logic [N-1:0] ent_resp_status;
    logic [N-1:0] ent_standby;

    rpt_commit_unit commit_i (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .cmt_valid    (cmt_valid),
        .cmt          (cmt),
        .cmp_hit      (cmp_hit),
        .entry_cmt    (entry_cmt)
    );

    for (genvar i = 0; i < N; i++) begin : g_entry
        rpt_entry entry_i (
            .core_clk        (core_clk),
            .core_reset_n    (core_reset_n),
            .prefetch_en     (prefetch_en),
            .entry_cmt       (entry_cmt[i]),
            .cmp_hit         (cmp_hit[i]),
            .prf_valid       (ent_valid[i]),
            .prf_req         (ent_req[i]),
            .prf_ready       (ent_ready[i]),
            .prf_ack_valid   (ent_ack_valid[i]),
            .prf_ack_replay  (ent_ack_replay[i]),
            .prf_resp_valid  (ent_resp_valid[i]),
            .prf_resp_status (ent_resp_status[i]),
            .standby_ready   (ent_standby[i])
        );
    end

    rpt_prefetch_arbiter arb_i (
        .core_clk        (core_clk),
        .core_reset_n    (core_reset_n),
        .ent_valid       (ent_valid),
        .ent_req         (ent_req),
        .ent_ready       (ent_ready),
        .ent_ack_valid   (ent_ack_valid),
        .ent_ack_replay  (ent_ack_replay),
        .ent_resp_valid  (ent_resp_valid),
        .ent_resp_status (ent_resp_status),
        .prf_valid       (prf_valid),
        .prf_req         (prf_req),
        .prf_ready       (prf_ready),
        .prf_ack_valid   (prf_ack_valid),
        .prf_ack_replay  (prf_ack_replay),
        .prf_resp_valid  (prf_resp_valid),
        .prf_resp_status (prf_resp_status)
    );

    assign standby_ready = &ent_standby; // idle only when every entry is.

endmodule

`default_nettype wire

/* design/rpt_prefetch_arbiter.sv */
// Prefetch request arbiter
`timescale 1ns/1ps
`default_nettype none
`include "rpt_settings.svh"

module rpt_prefetch_arbiter
    import rpt_pkg::*;
(
    input  wire logic                    core_clk,
    input  wire logic                    core_reset_n,
    input  wire logic [`RPT_ENTRIES-1:0] ent_valid,
    input  wire prf_req_t                ent_req [`RPT_ENTRIES],
    output logic [`RPT_ENTRIES-1:0]      ent_ready,
    output logic [`RPT_ENTRIES-1:0]      ent_ack_valid,
    output logic [`RPT_ENTRIES-1:0]      ent_ack_replay,
    output logic [`RPT_ENTRIES-1:0]      ent_resp_valid,
    output logic [`RPT_ENTRIES-1:0]      ent_resp_status,
    output logic                         prf_valid,
    output prf_req_t                     prf_req,
    input  wire logic                    prf_ready,
    input  wire logic                    prf_ack_valid,
    input  wire logic                    prf_ack_replay,
    input  wire logic                    prf_resp_valid,
    input  wire logic                    prf_resp_status
);

    localparam int N     = `RPT_ENTRIES;
    localparam int DEPTH = `RPT_RUN_AHEAD;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    entry_id_t       rr_ptr;
    entry_id_t       gnt_id;
    logic            room;
    logic            xfer;
    entry_id_t       own_q [2][DEPTH]; // 0 awaits ack, 1 awaits response.
    logic [PW-1:0]   wr_ptr [2];
    logic [PW-1:0]   rd_ptr [2];
    logic [CW-1:0]   own_cnt [2];
    logic [1:0]      push;
    logic [1:0]      pop;
    entry_id_t       push_id [2];
    entry_id_t       ack_owner;
    entry_id_t       resp_owner;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // first requester at or after the pointer.
    always_comb begin : pick_blk
        int idx;
        gnt_id = rr_ptr;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % N;
            if (ent_valid[idx]) begin
                gnt_id = entry_id_t'(idx);
            end
        end
    end

    // outstanding owners share one budget.
    assign room      = (own_cnt[0] + own_cnt[1]) < DEPTH;
    assign prf_valid = ent_valid[gnt_id] & room;
    assign prf_req   = ent_req[gnt_id];
    assign xfer      = prf_valid & prf_ready;

    assign ack_owner  = own_q[0][rd_ptr[0]];
    assign resp_owner = own_q[1][rd_ptr[1]];

    assign push[0]    = xfer;
    assign push_id[0] = gnt_id;
    assign pop[0]     = prf_ack_valid;
    assign push[1]    = prf_ack_valid & ~prf_ack_replay; // replays get no response.
    assign push_id[1] = ack_owner;
    assign pop[1]     = prf_resp_valid;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            rr_ptr <= '0;
            for (int f = 0; f < 2; f++) begin
                wr_ptr[f]  <= '0;
                rd_ptr[f]  <= '0;
                own_cnt[f] <= '0;
            end
        end else begin
            if (xfer) begin
                rr_ptr <= (gnt_id == entry_id_t'(N - 1)) ? '0 : gnt_id + 1'b1;
            end else if (prf_valid) begin
                rr_ptr <= gnt_id; // hold the grant while waiting.
            end
            for (int f = 0; f < 2; f++) begin
                if (push[f]) begin
                    wr_ptr[f] <= ptr_inc(wr_ptr[f]);
                end
                if (pop[f]) begin
                    rd_ptr[f] <= ptr_inc(rd_ptr[f]);
                end
                own_cnt[f] <= own_cnt[f] + CW'(push[f]) - CW'(pop[f]);
            end
        end
    end

    always_ff @(posedge core_clk) begin
        for (int f = 0; f < 2; f++) begin
            if (push[f]) begin
                own_q[f][wr_ptr[f]] <= push_id[f];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ent_ready[i]       = prf_ready & room & (gnt_id == entry_id_t'(i));
            ent_ack_valid[i]   = prf_ack_valid & (ack_owner == entry_id_t'(i));
            ent_ack_replay[i]  = prf_ack_replay & (ack_owner == entry_id_t'(i));
            ent_resp_valid[i]  = prf_resp_valid & (resp_owner == entry_id_t'(i));
            ent_resp_status[i] = prf_resp_status & (resp_owner == entry_id_t'(i));
        end
    end

    a_ack_not_empty: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        prf_ack_valid |-> own_cnt[0] != '0
    );

    a_resp_not_empty: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        prf_resp_valid |-> own_cnt[1] != '0
    );

    a_no_overflow: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        (own_cnt[0] + own_cnt[1]) <= DEPTH
    );

endmodule

`default_nettype wire

/* design/rpt_entry.sv */
// RPT entry with stride FSM
`timescale 1ns/1ps
`default_nettype none
`include "rpt_settings.svh"

module rpt_entry
    import rpt_pkg::*;
(
    input  wire logic       core_clk,
    input  wire logic       core_reset_n,
    input  wire logic       prefetch_en,
    input  wire entry_cmt_t entry_cmt,
    output logic            cmp_hit,
    output logic            prf_valid,
    output prf_req_t        prf_req,
    input  wire logic       prf_ready,
    input  wire logic       prf_ack_valid,
    input  wire logic       prf_ack_replay,
    input  wire logic       prf_resp_valid,
    input  wire logic       prf_resp_status,
    output logic            standby_ready
);

    localparam int VA_BITS   = `RPT_VA_BITS;
    localparam int LINE_LSB  = `RPT_LINE_LSB;
    localparam int RUN_AHEAD = `RPT_RUN_AHEAD;

    rpt_state_e              state;
    rpt_state_e              state_nxt;
    logic [`RPT_PC_BITS-1:0] tag_pc;
    logic                    tag_vm;
    logic [3:0]              tag_mtype;
    logic [VA_BITS-1:0]      last_va;
    logic [VA_BITS-1:0]      stride;
    logic [VA_BITS-1:0]      base;
    ra_cnt_t                 ra_cnt;
    logic                    inflight;
    logic                    ack_live;

    ld_commit_t              cmt;
    logic                    alloc;
    logic                    hit;
    logic                    same_line;
    logic                    attr_ok;
    logic                    train;
    logic                    predicted;
    logic                    kill;
    logic                    enter_steady;
    logic                    confirm;
    logic                    xfer;
    logic                    ack_adv;
    logic                    below_limit;

    assign cmt     = entry_cmt.cmt;
    assign cmp_hit = (state != ST_INVALID) && (tag_pc == cmt.pc);

    assign alloc = entry_cmt.valid & cmt.init & prefetch_en;
    assign hit   = entry_cmt.valid & ~cmt.init & cmp_hit;

    assign same_line = last_va[VA_BITS-1:LINE_LSB] == cmt.va[VA_BITS-1:LINE_LSB];
    assign attr_ok   = (tag_vm == cmt.status.vm) && (tag_mtype == cmt.status.mtype);
    assign train     = hit & ~same_line & ~cmt.status.no_stride;
    assign predicted = (last_va + stride == cmt.va) && attr_ok;

    assign kill = ~prefetch_en
                | (prf_resp_valid & prf_resp_status)
                | (hit & cmt.status.fault)
                | (hit & ~attr_ok);

    always_comb begin
        state_nxt = state;
        if (state == ST_INVALID) begin
            if (alloc) begin
                state_nxt = ST_INIT;
            end
        end else if (kill) begin
            state_nxt = ST_INVALID;
        end else if (alloc) begin
            state_nxt = ST_INIT; // taken over as a victim.
        end else if (train) begin
            if (state == ST_INIT) begin
                state_nxt = ST_TRANSIENT;
            end else if (predicted) begin
                state_nxt = ST_STEADY;
            end else begin
                state_nxt = ST_INIT;
            end
        end
    end

    assign enter_steady = (state == ST_TRANSIENT) && (state_nxt == ST_STEADY);
    assign confirm      = (state == ST_STEADY) && (state_nxt == ST_STEADY) && train;
    assign xfer         = prf_valid & prf_ready;
    assign ack_adv      = prf_ack_valid & ~prf_ack_replay & ack_live;
    assign below_limit  = ra_cnt < RUN_AHEAD;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state <= ST_INVALID;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge core_clk) begin
        if (alloc) begin
            tag_pc    <= cmt.pc;
            tag_vm    <= cmt.status.vm;
            tag_mtype <= cmt.status.mtype;
        end
        if (alloc | train) begin
            last_va <= cmt.va;
        end
        if (train && state != ST_STEADY) begin
            stride <= cmt.va - last_va;
        end
        if (enter_steady) begin
            base <= cmt.va;
        end else if (ack_adv) begin
            base <= base + stride; // replays keep the old base.
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            ra_cnt   <= '0;
            inflight <= 1'b0;
            ack_live <= 1'b0;
        end else begin
            inflight <= xfer | (inflight & ~prf_ack_valid);
            if (enter_steady) begin
                ack_live <= 1'b0; // older acks must not move the new base.
            end else if (xfer) begin
                ack_live <= 1'b1;
            end
            if (enter_steady) begin
                ra_cnt <= '0;
            end else begin
                ra_cnt <= ra_cnt + ra_cnt_t'(ack_adv) - ra_cnt_t'(confirm && ra_cnt != '0);
            end
        end
    end

    assign prf_valid = (state == ST_STEADY) & below_limit & ~inflight & ~kill;

    assign prf_req.pc    = tag_pc;
    assign prf_req.va    = base + stride;
    assign prf_req.vm    = tag_vm;
    assign prf_req.mtype = tag_mtype;

    assign standby_ready = ~((state == ST_STEADY) & below_limit) & ~inflight;

    a_state_onehot: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        $onehot(state)
    );

    // quiet from transfer until its acknowledgement.
    a_one_in_flight: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        xfer |=> !prf_valid until_with prf_ack_valid
    );

    a_ack_owner: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        prf_ack_valid |-> inflight
    );

endmodule

`default_nettype wire

/* design/rpt_commit_unit.sv */
// RPT commit steering
`timescale 1ns/1ps
`default_nettype none
`include "rpt_settings.svh"

module rpt_commit_unit
    import rpt_pkg::*;
(
    input  wire logic                    core_clk,
    input  wire logic                    core_reset_n,
    input  wire logic                    cmt_valid,
    input  wire ld_commit_t              cmt,
    input  wire logic [`RPT_ENTRIES-1:0] cmp_hit,
    output entry_cmt_t                   entry_cmt [`RPT_ENTRIES]
);

    localparam int N = `RPT_ENTRIES;

    entry_id_t      victim_ptr;
    logic           hit_any;
    logic           alloc;
    logic [N-1:0]   alloc_sel;

    assign hit_any = |cmp_hit;

    // only a loop start hint may claim a new entry.
    assign alloc = cmt_valid & ~hit_any & cmt.init;

    assign alloc_sel = alloc ? ({{(N - 1){1'b0}}, 1'b1} << victim_ptr) : '0;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            victim_ptr <= '0;
        end else if (alloc) begin
            victim_ptr <= (victim_ptr == entry_id_t'(N - 1)) ? '0 : victim_ptr + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            entry_cmt[i].cmt      = cmt;
            entry_cmt[i].cmt.init = alloc_sel[i]; // allocate marker.
            entry_cmt[i].valid    = (cmt_valid & cmp_hit[i]) | alloc_sel[i];
        end
    end

    // table tags must stay unique across entries.
    a_single_hit: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        cmt_valid |-> $onehot0(cmp_hit)
    );

endmodule

`default_nettype wire

/* design/rpt_pkg.sv */
// Stride prefetcher types
`default_nettype none
`include "rpt_settings.svh"

package rpt_pkg;

    typedef logic [$clog2(`RPT_ENTRIES)-1:0] entry_id_t;

    typedef logic [$clog2(`RPT_RUN_AHEAD + 1)-1:0] ra_cnt_t; // run-ahead count.

    typedef struct packed {
        logic       vm;        // translation mode.
        logic [3:0] mtype;
        logic       no_stride; // access must not train.
        logic       fault;
    } ld_status_t;

    typedef struct packed {
        logic [`RPT_PC_BITS-1:0] pc;
        logic [`RPT_VA_BITS-1:0] va;
        logic                    init; // loop start hint.
        ld_status_t              status;
    } ld_commit_t;

    // init here means allocate.
    typedef struct packed {
        logic       valid;
        ld_commit_t cmt;
    } entry_cmt_t;

    typedef struct packed {
        logic [`RPT_PC_BITS-1:0] pc;
        logic [`RPT_VA_BITS-1:0] va;
        logic                    vm;
        logic [3:0]              mtype;
    } prf_req_t;

    typedef enum logic [3:0] {
        ST_INVALID   = 4'b0001,
        ST_INIT      = 4'b0010,
        ST_TRANSIENT = 4'b0100,
        ST_STEADY    = 4'b1000
    } rpt_state_e;

endpackage

`default_nettype wire

/* design/rpt_settings.svh */
// Stride prefetcher settings
`ifndef RPT_SETTINGS_SVH
`define RPT_SETTINGS_SVH

// virtual address width.
`define RPT_VA_BITS 32

// number of reference prediction table entries.
`define RPT_ENTRIES 4

// lowest address bit that names a cache line.
`define RPT_LINE_LSB 6

// most prefetches an entry may run ahead of its loads.
`define RPT_RUN_AHEAD 3

// width of the load instruction tag.
`define RPT_PC_BITS 12

`endif
